/* common/isa_pkg.sv */
package isa_pkg;

    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;

    localparam reg_addr_t REG_ZERO = 5'd0;

    // r-type layout, i-type immediate sits on rd/shamt/funct
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        shamt_t     shamt;
        logic [5:0] funct;
    } inst_fields_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI
    } alu_op_t;

    //////////////////////////////
    localparam logic [5:0] OPCODE_SPECIAL = 6'h00;
    localparam logic [5:0] OPCODE_ADDIU   = 6'h09;
    localparam logic [5:0] OPCODE_SLTI    = 6'h0a;
    localparam logic [5:0] OPCODE_SLTIU   = 6'h0b;
    localparam logic [5:0] OPCODE_ANDI    = 6'h0c;
    localparam logic [5:0] OPCODE_ORI     = 6'h0d;
    localparam logic [5:0] OPCODE_XORI    = 6'h0e;
    localparam logic [5:0] OPCODE_LUI     = 6'h0f;

    // funct field, opcode special only
    localparam logic [5:0] FUNCT_SLL  = 6'h00;
    localparam logic [5:0] FUNCT_SRL  = 6'h02;
    localparam logic [5:0] FUNCT_SRA  = 6'h03;
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_SUBU = 6'h23;
    localparam logic [5:0] FUNCT_AND  = 6'h24;
    localparam logic [5:0] FUNCT_OR   = 6'h25;
    localparam logic [5:0] FUNCT_XOR  = 6'h26;
    localparam logic [5:0] FUNCT_NOR  = 6'h27;
    localparam logic [5:0] FUNCT_SLT  = 6'h2a;
    localparam logic [5:0] FUNCT_SLTU = 6'h2b;

endpackage

/* common/pipe_pkg.sv */
package pipe_pkg;

    // fetch to decode
    typedef struct packed {
        isa_pkg::data_t inst;
    } dec_payload_t;

    // decode to exec, operands already forwarded
    typedef struct packed {
        isa_pkg::alu_op_t   alu_op;
        isa_pkg::data_t     a;
        isa_pkg::data_t     b;      // rt or immediate
        isa_pkg::shamt_t    shamt;
        logic               wb_en;
        isa_pkg::reg_addr_t dest;
    } exec_payload_t;

    // exec to mem, mem to wb
    typedef struct packed {
        logic               wb_en;
        isa_pkg::reg_addr_t dest;
        isa_pkg::data_t     result;
    } mem_payload_t;

    // writeback port
    typedef struct packed {
        isa_pkg::reg_addr_t dest;
        isa_pkg::data_t     data;
    } wb_result_t;

endpackage

/* src/stage_reg.sv */
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     valid_in,
    input  payload_t payload_in,
    output logic     valid_out,
    output payload_t payload_out
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid_out <= 1'b0;
        else
            valid_out <= valid_in;  // no stall, loads every cycle
    end

    always_ff @(posedge clk)
    begin
        payload_out <= payload_in;
    end

    // upstream stage must hand over a fully known payload with valid
    a_payload_known: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> !$isunknown(payload_out));

endmodule

/* src/decoder.sv */
module decoder (
    input  isa_pkg::data_t     inst,
    output isa_pkg::reg_addr_t rs_addr,
    output isa_pkg::reg_addr_t rt_addr,
    output isa_pkg::reg_addr_t rd_addr,
    output isa_pkg::alu_op_t   alu_op,
    output logic               use_imm,
    output isa_pkg::data_t     imm,
    output isa_pkg::shamt_t    shamt,
    output logic               wb_en
);

    isa_pkg::inst_fields_t f;
    logic [15:0]           imm16;
    logic                  sign_ext;

    assign f       = isa_pkg::inst_fields_t'(inst);
    assign imm16   = {f.rd, f.shamt, f.funct};
    assign rs_addr = f.rs;
    assign rt_addr = f.rt;
    assign shamt   = f.shamt;

    // andi/ori/xori zero extend, lui only uses the low half
    assign sign_ext = (f.opcode == isa_pkg::OPCODE_ADDIU) ||
                      (f.opcode == isa_pkg::OPCODE_SLTI) ||
                      (f.opcode == isa_pkg::OPCODE_SLTIU);
    assign imm = sign_ext ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};

    always_comb
    begin
        alu_op  = isa_pkg::ALU_ADD;
        use_imm = 1'b0;
        wb_en   = 1'b0;
        rd_addr = f.rd;
        case (f.opcode)
            isa_pkg::OPCODE_SPECIAL:
            begin
                wb_en = 1'b1;
                case (f.funct)
                    isa_pkg::FUNCT_ADDU: alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::FUNCT_SUBU: alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::FUNCT_AND:  alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FUNCT_OR:   alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FUNCT_XOR:  alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::FUNCT_NOR:  alu_op = isa_pkg::ALU_NOR;
                    isa_pkg::FUNCT_SLT:  alu_op = isa_pkg::ALU_SLT;
                    isa_pkg::FUNCT_SLTU: alu_op = isa_pkg::ALU_SLTU;
                    isa_pkg::FUNCT_SLL:  alu_op = isa_pkg::ALU_SLL;
                    isa_pkg::FUNCT_SRL:  alu_op = isa_pkg::ALU_SRL;
                    isa_pkg::FUNCT_SRA:  alu_op = isa_pkg::ALU_SRA;
                    default:             wb_en  = 1'b0;  // unknown funct
                endcase
            end
            default:
            begin
                // i-type, result goes to rt
                rd_addr = f.rt;
                use_imm = 1'b1;
                wb_en   = 1'b1;
                case (f.opcode)
                    isa_pkg::OPCODE_ADDIU: alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::OPCODE_SLTI:  alu_op = isa_pkg::ALU_SLT;
                    isa_pkg::OPCODE_SLTIU: alu_op = isa_pkg::ALU_SLTU;
                    isa_pkg::OPCODE_ANDI:  alu_op = isa_pkg::ALU_AND;
                    isa_pkg::OPCODE_ORI:   alu_op = isa_pkg::ALU_OR;
                    isa_pkg::OPCODE_XORI:  alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::OPCODE_LUI:   alu_op = isa_pkg::ALU_LUI;
                    default:               wb_en  = 1'b0;  // empty slot
                endcase
            end
        endcase
    end

endmodule

/* src/register_file.sv */
module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::reg_addr_t rs_addr,
    input  isa_pkg::reg_addr_t rt_addr,
    input  logic               we,
    input  isa_pkg::reg_addr_t waddr,
    input  isa_pkg::data_t     wdata,
    output isa_pkg::data_t     rs_data,
    output isa_pkg::data_t     rt_data
);

    isa_pkg::data_t regs [1:31];  // $zero has no storage

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && waddr != isa_pkg::REG_ZERO)
        begin
            regs[waddr] <= wdata;
        end
    end

    // combinational read, a write lands at the edge
    assign rs_data = (rs_addr == isa_pkg::REG_ZERO) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == isa_pkg::REG_ZERO) ? '0 : regs[rt_addr];

    // the core drops writes to $zero before they reach the file
    a_no_zero_write: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> waddr != isa_pkg::REG_ZERO);

endmodule

/* src/forwarding_unit.sv */
module forwarding_unit (
    input  isa_pkg::reg_addr_t     rs_addr,
    input  isa_pkg::reg_addr_t     rt_addr,
    input  isa_pkg::data_t         rs_file,
    input  isa_pkg::data_t         rt_file,
    input  pipe_pkg::mem_payload_t exec_fwd,
    input  pipe_pkg::mem_payload_t mem_fwd,
    input  pipe_pkg::mem_payload_t wb_fwd,
    output isa_pkg::data_t         rs_value,
    output isa_pkg::data_t         rt_value
);

    function automatic logic hit(
        input pipe_pkg::mem_payload_t src,
        input isa_pkg::reg_addr_t     addr
    );
        return src.wb_en && src.dest == addr;
    endfunction

    // youngest writer wins
    function automatic isa_pkg::data_t pick(
        input isa_pkg::reg_addr_t addr,
        input isa_pkg::data_t     file_value
    );
        if (addr == isa_pkg::REG_ZERO)
            return '0;
        else if (hit(exec_fwd, addr))
            return exec_fwd.result;
        else if (hit(mem_fwd, addr))
            return mem_fwd.result;
        else if (hit(wb_fwd, addr))
            return wb_fwd.result;  // not in the file until next edge
        else
            return file_value;
    endfunction

    always_comb
    begin
        rs_value = pick(rs_addr, rs_file);
        rt_value = pick(rt_addr, rt_file);
    end

endmodule

/* src/alu.sv */
module alu (
    input  isa_pkg::alu_op_t op,
    input  isa_pkg::data_t   a,
    input  isa_pkg::data_t   b,
    input  isa_pkg::shamt_t  shamt,
    output isa_pkg::data_t   result
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb
    begin
        case (op)
            // arithmetic, no overflow trap
            isa_pkg::ALU_ADD:  result = a + b;
            isa_pkg::ALU_SUB:  result = a - b;

            isa_pkg::ALU_AND:  result = a & b;
            isa_pkg::ALU_OR:   result = a | b;
            isa_pkg::ALU_XOR:  result = a ^ b;
            isa_pkg::ALU_NOR:  result = ~(a | b);

            isa_pkg::ALU_SLT:  result = {31'b0, lt_signed};
            isa_pkg::ALU_SLTU: result = {31'b0, lt_unsigned};

            // shifts act on rt
            isa_pkg::ALU_SLL:  result = b << shamt;
            isa_pkg::ALU_SRL:  result = b >> shamt;
            isa_pkg::ALU_SRA:  result = $signed(b) >>> shamt;

            isa_pkg::ALU_LUI:  result = {b[15:0], 16'h0000};
            default:           result = '0;
        endcase
    end

endmodule

/* src/mips_core.sv */
module mips_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 inst_valid,
    input  isa_pkg::data_t       inst,
    output logic                 wb_valid,
    output pipe_pkg::wb_result_t wb
);

    pipe_pkg::dec_payload_t  fd_in;
    pipe_pkg::dec_payload_t  dec_pl;
    logic                    dec_valid;
    isa_pkg::reg_addr_t      dec_rs_addr;
    isa_pkg::reg_addr_t      dec_rt_addr;
    isa_pkg::reg_addr_t      dec_dest;
    isa_pkg::alu_op_t        dec_alu_op;
    logic                    dec_use_imm;
    isa_pkg::data_t          dec_imm;
    isa_pkg::shamt_t         dec_shamt;
    logic                    dec_wb_en;
    isa_pkg::data_t          rs_file;
    isa_pkg::data_t          rt_file;
    isa_pkg::data_t          rs_value;
    isa_pkg::data_t          rt_value;
    pipe_pkg::exec_payload_t de_in;
    pipe_pkg::exec_payload_t exec_pl;
    logic                    exec_valid;
    isa_pkg::data_t          exec_res;
    pipe_pkg::mem_payload_t  em_in;
    pipe_pkg::mem_payload_t  mem_pl;
    logic                    mem_valid;
    pipe_pkg::mem_payload_t  wb_pl;
    logic                    wb_stage_valid;
    pipe_pkg::mem_payload_t  exec_fwd;
    pipe_pkg::mem_payload_t  mem_fwd;
    pipe_pkg::mem_payload_t  wb_fwd;

    ////////////////////////////// fetch to decode
    assign fd_in.inst = inst;

    stage_reg #(.payload_t(pipe_pkg::dec_payload_t)) u_fd (
        .clk(clk), .rst_n(rst_n),
        .valid_in(inst_valid), .payload_in(fd_in),
        .valid_out(dec_valid), .payload_out(dec_pl)
    );

    decoder u_decoder (
        .inst(dec_pl.inst),
        .rs_addr(dec_rs_addr), .rt_addr(dec_rt_addr), .rd_addr(dec_dest),
        .alu_op(dec_alu_op), .use_imm(dec_use_imm), .imm(dec_imm),
        .shamt(dec_shamt), .wb_en(dec_wb_en)
    );

    register_file u_register_file (
        .clk(clk), .rst_n(rst_n),
        .rs_addr(dec_rs_addr), .rt_addr(dec_rt_addr),
        .we(wb_valid), .waddr(wb_pl.dest), .wdata(wb_pl.result),
        .rs_data(rs_file), .rt_data(rt_file)
    );

    // writers only count while their stage holds a valid slot
    assign exec_fwd = '{wb_en: exec_valid && em_in.wb_en, dest: em_in.dest, result: exec_res};
    assign mem_fwd  = '{wb_en: mem_valid && mem_pl.wb_en, dest: mem_pl.dest, result: mem_pl.result};
    assign wb_fwd   = '{wb_en: wb_valid, dest: wb_pl.dest, result: wb_pl.result};

    forwarding_unit u_forwarding_unit (
        .rs_addr(dec_rs_addr), .rt_addr(dec_rt_addr),
        .rs_file(rs_file), .rt_file(rt_file),
        .exec_fwd(exec_fwd), .mem_fwd(mem_fwd), .wb_fwd(wb_fwd),
        .rs_value(rs_value), .rt_value(rt_value)
    );

    ////////////////////////////// decode to exec
    assign de_in = '{alu_op: dec_alu_op, a: rs_value,
                     b: dec_use_imm ? dec_imm : rt_value,  // immediate select
                     shamt: dec_shamt, wb_en: dec_wb_en, dest: dec_dest};

    stage_reg #(.payload_t(pipe_pkg::exec_payload_t)) u_de (
        .clk(clk), .rst_n(rst_n),
        .valid_in(dec_valid), .payload_in(de_in),
        .valid_out(exec_valid), .payload_out(exec_pl)
    );

    alu u_alu (
        .op(exec_pl.alu_op), .a(exec_pl.a), .b(exec_pl.b),
        .shamt(exec_pl.shamt), .result(exec_res)
    );

    assign em_in = '{wb_en: exec_pl.wb_en, dest: exec_pl.dest, result: exec_res};

    ////////////////////////////// exec to mem to wb
    stage_reg #(.payload_t(pipe_pkg::mem_payload_t)) u_em (
        .clk(clk), .rst_n(rst_n),
        .valid_in(exec_valid), .payload_in(em_in),
        .valid_out(mem_valid), .payload_out(mem_pl)
    );

    // mem stage is a pass-through slot
    stage_reg #(.payload_t(pipe_pkg::mem_payload_t)) u_mw (
        .clk(clk), .rst_n(rst_n),
        .valid_in(mem_valid), .payload_in(mem_pl),
        .valid_out(wb_stage_valid), .payload_out(wb_pl)
    );

    assign wb_valid = wb_stage_valid && wb_pl.wb_en && wb_pl.dest != isa_pkg::REG_ZERO;
    assign wb       = '{dest: wb_pl.dest, data: wb_pl.result};

endmodule

/* tests/tb_mips_core.sv */
module tb_mips_core;

    localparam int N_DIRECTED     = 42;
    localparam int N_RANDOM       = 600;
    // at most one idle slot per issue, plus reset and drain
    localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 2 + 216;

    typedef struct packed {
        logic [31:0]        due;
        isa_pkg::reg_addr_t dest;
        isa_pkg::data_t     data;
    } exp_wb_t;

    logic                 clk;
    logic                 rst_n;
    logic                 inst_valid;
    isa_pkg::data_t       inst;
    logic                 wb_valid;
    pipe_pkg::wb_result_t wb;

    logic [31:0]    cycle_count = '0;
    isa_pkg::data_t shadow [32];  // architectural state as of the last issue
    exp_wb_t        expected_q [$];

    mips_core u_dut (
        .clk(clk),
        .rst_n(rst_n),
        .inst_valid(inst_valid),
        .inst(inst),
        .wb_valid(wb_valid),
        .wb(wb)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    always @(posedge clk)
    begin
        if (cycle_count >= TIMEOUT_CYCLES)
            fail_run("timeout, writebacks did not drain in time");
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            fail_run("value mismatch on the writeback port");
        end
    endtask

    ////////////////////////////// encoders
    function automatic isa_pkg::data_t encode_r(input logic [5:0] funct,
                                                input isa_pkg::reg_addr_t rd,
                                                input isa_pkg::reg_addr_t rs,
                                                input isa_pkg::reg_addr_t rt,
                                                input isa_pkg::shamt_t sa);
        return {isa_pkg::OPCODE_SPECIAL, rs, rt, rd, sa, funct};
    endfunction

    function automatic isa_pkg::data_t encode_i(input logic [5:0] opcode,
                                                input isa_pkg::reg_addr_t rt,
                                                input isa_pkg::reg_addr_t rs,
                                                input logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    ////////////////////////////// reference model
    function automatic void exec_ref(input isa_pkg::data_t word, output logic writes,
                                     output isa_pkg::reg_addr_t dest,
                                     output isa_pkg::data_t value);
        logic [5:0]      opcode;
        logic [5:0]      funct;
        isa_pkg::shamt_t sa;
        isa_pkg::data_t  a;
        isa_pkg::data_t  b;
        isa_pkg::data_t  imm_s;
        isa_pkg::data_t  imm_z;
        opcode = word[31:26];
        funct  = word[5:0];
        sa     = word[10:6];
        a      = shadow[word[25:21]];
        b      = shadow[word[20:16]];
        imm_s  = {{16{word[15]}}, word[15:0]};
        imm_z  = {16'h0000, word[15:0]};
        writes = 1'b1;
        value  = '0;
        if (opcode == isa_pkg::OPCODE_SPECIAL)
        begin
            dest = word[15:11];
            case (funct)
                isa_pkg::FUNCT_ADDU: value = a + b;
                isa_pkg::FUNCT_SUBU: value = a - b;
                isa_pkg::FUNCT_AND:  value = a & b;
                isa_pkg::FUNCT_OR:   value = a | b;
                isa_pkg::FUNCT_XOR:  value = a ^ b;
                isa_pkg::FUNCT_NOR:  value = ~(a | b);
                isa_pkg::FUNCT_SLT:  value = {31'b0, $signed(a) < $signed(b)};
                isa_pkg::FUNCT_SLTU: value = {31'b0, a < b};
                isa_pkg::FUNCT_SLL:  value = b << sa;
                isa_pkg::FUNCT_SRL:  value = b >> sa;
                isa_pkg::FUNCT_SRA:  value = $signed(b) >>> sa;
                default:             writes = 1'b0;
            endcase
        end
        else
        begin
            dest = word[20:16];
            case (opcode)
                isa_pkg::OPCODE_ADDIU: value = a + imm_s;
                isa_pkg::OPCODE_SLTI:  value = {31'b0, $signed(a) < $signed(imm_s)};
                isa_pkg::OPCODE_SLTIU: value = {31'b0, a < imm_s};
                isa_pkg::OPCODE_ANDI:  value = a & imm_z;
                isa_pkg::OPCODE_ORI:   value = a | imm_z;
                isa_pkg::OPCODE_XORI:  value = a ^ imm_z;
                isa_pkg::OPCODE_LUI:   value = {word[15:0], 16'h0000};
                default:               writes = 1'b0;
            endcase
        end
        if (dest == isa_pkg::REG_ZERO)
            writes = 1'b0;  // $zero never shows up on the port
    endfunction

    ////////////////////////////// stimulus
    task automatic issue_inst(input isa_pkg::data_t word);
        exp_wb_t            entry;
        logic               writes;
        isa_pkg::reg_addr_t dest;
        isa_pkg::data_t     value;
        exec_ref(word, writes, dest, value);
        if (writes)
        begin
            entry.due  = cycle_count + 4;  // sampled next edge, visible 3 edges later
            entry.dest = dest;
            entry.data = value;
            expected_q.push_back(entry);
            shadow[dest] = value;
        end
        inst_valid = 1'b1;
        inst       = word;
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        inst_valid = 1'b0;
        inst       = $urandom();  // ignored while not valid
        repeat (n) @(posedge clk);
        #1;
    endtask

    function automatic isa_pkg::data_t random_inst();
        int                 sel;
        isa_pkg::reg_addr_t rd;
        isa_pkg::reg_addr_t rs;
        isa_pkg::reg_addr_t rt;
        isa_pkg::shamt_t    sa;
        logic [15:0]        imm;
        sel = $urandom_range(0, 19);
        rd  = 5'($urandom_range(0, 7));
        rs  = 5'($urandom_range(0, 7));
        rt  = 5'($urandom_range(0, 7));
        sa  = 5'($urandom());
        imm = 16'($urandom());
        case (sel)
            0:  return encode_r(isa_pkg::FUNCT_ADDU, rd, rs, rt, 5'd0);
            1:  return encode_r(isa_pkg::FUNCT_SUBU, rd, rs, rt, 5'd0);
            2:  return encode_r(isa_pkg::FUNCT_AND, rd, rs, rt, 5'd0);
            3:  return encode_r(isa_pkg::FUNCT_OR, rd, rs, rt, 5'd0);
            4:  return encode_r(isa_pkg::FUNCT_XOR, rd, rs, rt, 5'd0);
            5:  return encode_r(isa_pkg::FUNCT_NOR, rd, rs, rt, 5'd0);
            6:  return encode_r(isa_pkg::FUNCT_SLT, rd, rs, rt, 5'd0);
            7:  return encode_r(isa_pkg::FUNCT_SLTU, rd, rs, rt, 5'd0);
            8:  return encode_r(isa_pkg::FUNCT_SLL, rd, 5'd0, rt, sa);
            9:  return encode_r(isa_pkg::FUNCT_SRL, rd, 5'd0, rt, sa);
            10: return encode_r(isa_pkg::FUNCT_SRA, rd, 5'd0, rt, sa);
            11: return encode_i(isa_pkg::OPCODE_ADDIU, rt, rs, imm);
            12: return encode_i(isa_pkg::OPCODE_SLTI, rt, rs, imm);
            13: return encode_i(isa_pkg::OPCODE_SLTIU, rt, rs, imm);
            14: return encode_i(isa_pkg::OPCODE_ANDI, rt, rs, imm);
            15: return encode_i(isa_pkg::OPCODE_ORI, rt, rs, imm);
            16: return encode_i(isa_pkg::OPCODE_XORI, rt, rs, imm);
            17: return encode_i(isa_pkg::OPCODE_LUI, rt, 5'd0, imm);
            18: return encode_i(6'h23, rt, rs, imm);  // load, unsupported
            default: return $urandom();
        endcase
    endfunction

    ////////////////////////////// writeback compare
    always @(negedge clk)
    begin
        if (expected_q.size() != 0 && expected_q[0].due == cycle_count)
        begin
            check_value("wb_valid", {31'b0, wb_valid}, 32'd1);
            check_value("wb.dest", {27'b0, wb.dest}, {27'b0, expected_q[0].dest});
            check_value("wb.data", wb.data, expected_q[0].data);
            void'(expected_q.pop_front());
        end
        else
        begin
            check_value("wb_valid", {31'b0, wb_valid}, 32'd0);
        end
    end

    initial
    begin
        void'($urandom(32'hb8b8));
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        for (int r = 0; r < 32; r++)
            shadow[r] = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle_cycles(3);

        // registers still hold zero
        issue_inst(encode_r(isa_pkg::FUNCT_ADDU, 5'd3, 5'd1, 5'd2, 5'd0));
        issue_inst(encode_r(isa_pkg::FUNCT_NOR, 5'd4, 5'd5, 5'd6, 5'd0));

        // immediate extension
        issue_inst(encode_i(isa_pkg::OPCODE_ADDIU, 5'd1, 5'd0, 16'h8001));
        issue_inst(encode_i(isa_pkg::OPCODE_ORI, 5'd2, 5'd0, 16'h8001));
        issue_inst(encode_i(isa_pkg::OPCODE_ANDI, 5'd3, 5'd1, 16'hf0f0));
        issue_inst(encode_i(isa_pkg::OPCODE_XORI, 5'd4, 5'd1, 16'hffff));
        issue_inst(encode_i(isa_pkg::OPCODE_LUI, 5'd5, 5'd0, 16'h8765));
        issue_inst(encode_i(isa_pkg::OPCODE_SLTI, 5'd6, 5'd1, 16'hffff));
        issue_inst(encode_i(isa_pkg::OPCODE_SLTIU, 5'd7, 5'd1, 16'hffff));
        issue_inst(encode_i(isa_pkg::OPCODE_SLTIU, 5'd6, 5'd2, 16'h8000));

        // r-type with a negative and a positive operand
        issue_inst(encode_r(isa_pkg::FUNCT_ADDU, 5'd3, 5'd1, 5'd2, 5'd0));
        issue_inst(encode_r(isa_pkg::FUNCT_SUBU, 5'd3, 5'd2, 5'd1, 5'd0));
        issue_inst(encode_r(isa_pkg::FUNCT_AND, 5'd4, 5'd1, 5'd2, 5'd0));
        issue_inst(encode_r(isa_pkg::FUNCT_OR, 5'd5, 5'd1, 5'd2, 5'd0));
        issue_inst(encode_r(isa_pkg::FUNCT_XOR, 5'd6, 5'd1, 5'd2, 5'd0));
        issue_inst(encode_r(isa_pkg::FUNCT_NOR, 5'd7, 5'd1, 5'd2, 5'd0));
        issue_inst(encode_r(isa_pkg::FUNCT_SLT, 5'd3, 5'd1, 5'd2, 5'd0));
        issue_inst(encode_r(isa_pkg::FUNCT_SLTU, 5'd4, 5'd1, 5'd2, 5'd0));
        issue_inst(encode_r(isa_pkg::FUNCT_SLL, 5'd5, 5'd0, 5'd1, 5'd4));
        issue_inst(encode_r(isa_pkg::FUNCT_SRL, 5'd6, 5'd0, 5'd1, 5'd4));
        issue_inst(encode_r(isa_pkg::FUNCT_SRA, 5'd7, 5'd0, 5'd1, 5'd4));
        issue_inst(encode_r(isa_pkg::FUNCT_SRA, 5'd3, 5'd0, 5'd2, 5'd15));

        // consumer at distance 1 to 4
        for (int d = 0; d < 4; d++)
        begin
            issue_inst(encode_i(isa_pkg::OPCODE_ADDIU, 5'd5, 5'd0, 16'(32'h0100 + d)));
            idle_cycles(d);
            issue_inst(encode_r(isa_pkg::FUNCT_ADDU, 5'd6, 5'd5, 5'd5, 5'd0));
        end

        // same dest in exec, mem and wb, youngest must win
        issue_inst(encode_i(isa_pkg::OPCODE_ADDIU, 5'd1, 5'd0, 16'h0001));
        issue_inst(encode_i(isa_pkg::OPCODE_ADDIU, 5'd1, 5'd0, 16'h0002));
        issue_inst(encode_i(isa_pkg::OPCODE_ADDIU, 5'd1, 5'd0, 16'h0003));
        issue_inst(encode_r(isa_pkg::FUNCT_ADDU, 5'd2, 5'd1, 5'd1, 5'd0));

        // no writeback for $zero targets and unsupported words
        issue_inst(encode_i(isa_pkg::OPCODE_ADDIU, 5'd0, 5'd0, 16'h0055));
        issue_inst(encode_r(isa_pkg::FUNCT_ADDU, 5'd0, 5'd1, 5'd1, 5'd0));
        issue_inst(encode_i(6'h23, 5'd2, 5'd0, 16'h1234));
        issue_inst(32'hffff_ffff);
        issue_inst(encode_r(6'h08, 5'd3, 5'd1, 5'd0, 5'd0));
        issue_inst(32'h0000_0000);
        issue_inst(encode_r(isa_pkg::FUNCT_ADDU, 5'd3, 5'd2, 5'd0, 5'd0));
        issue_inst(encode_r(isa_pkg::FUNCT_OR, 5'd4, 5'd0, 5'd0, 5'd0));

        for (int i = 0; i < N_RANDOM; i++)
        begin
            issue_inst(random_inst());
            if ($urandom_range(0, 3) == 0)
                idle_cycles(1);
        end

        // drain, then make sure nothing else shows up
        while (expected_q.size() != 0)
            @(posedge clk);
        repeat (8) @(posedge clk);

        $display("Test OK");
        $finish;
    end

endmodule

/* src.f */
common/isa_pkg.sv
common/pipe_pkg.sv
src/stage_reg.sv
src/decoder.sv
src/register_file.sv
src/forwarding_unit.sv
src/alu.sv
src/mips_core.sv
tests/tb_mips_core.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mips_core -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_mips_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
